/* alu_iq_macros.svh */
`ifndef ALU_IQ_MACROS_SVH
`define ALU_IQ_MACROS_SVH

// ----------------------------------------------------------------------
// queue sizing
// ----------------------------------------------------------------------

// number of queue entries, 2, 4 or 8
`define IQ_DEPTH 4

// saturating age counter width per entry
`define AGE_BITS 4

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

`define TAG_BITS 4
`define WORD_BITS 32

`endif

/* alu_iq_pkg.sv */
`default_nettype none

`include "alu_iq_macros.svh"

package alu_iq_pkg;

    // ----------------------------------------------------------------------
    // datapath types
    // ----------------------------------------------------------------------

    typedef logic [`WORD_BITS-1:0] word_t;

    // physical register tag, shared by dispatch, cdb and result bus
    typedef logic [`TAG_BITS-1:0] tag_t;

    // ----------------------------------------------------------------------
    // opcodes and entry states
    // ----------------------------------------------------------------------

    // shifts take the low 5 bits of operand 1, slt is a signed compare
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // waiting means at least one operand still missing
    typedef enum logic [1:0] {
        EMPTY   = 2'd0,
        WAITING = 2'd1,
        READY   = 2'd2
    } entry_state_e;

endpackage

`default_nettype wire

/* iq_entry.sv */
`default_nettype none

module iq_entry
    import alu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,

    input  logic    alloc_i,
    input  logic    issue_i,

    // dispatch payload
    input  alu_op_e op_i,
    input  tag_t    dst_tag_i,
    input  word_t   src0_data_i,
    input  tag_t    src0_tag_i,
    input  logic    src0_rdy_i,
    input  word_t   src1_data_i,
    input  tag_t    src1_tag_i,
    input  logic    src1_rdy_i,

    // external wakeup bus
    input  logic    cdb_valid_i,
    input  tag_t    cdb_tag_i,
    input  word_t   cdb_data_i,

    // own alu result fed back
    input  logic    fwd_valid_i,
    input  tag_t    fwd_tag_i,
    input  word_t   fwd_data_i,

    output logic    occupied_o,
    output logic    ready_o,
    output alu_op_e op_o,
    output tag_t    dst_tag_o,
    output word_t   opnd0_o,
    output word_t   opnd1_o
);

    entry_state_e state_q;

    alu_op_e op_q;
    tag_t    dst_tag_q;

    // per-operand storage, index 0 and 1
    logic    rdy_q   [2];
    tag_t    tag_q   [2];
    word_t   data_q  [2];

    logic    src_rdy  [2];
    tag_t    src_tag  [2];
    word_t   src_data [2];

    logic    base_rdy [2];
    tag_t    base_tag [2];
    word_t   base_data[2];
    logic    nxt_rdy  [2];
    word_t   nxt_data [2];

    assign src_rdy[0]  = src0_rdy_i;
    assign src_rdy[1]  = src1_rdy_i;
    assign src_tag[0]  = src0_tag_i;
    assign src_tag[1]  = src1_tag_i;
    assign src_data[0] = src0_data_i;
    assign src_data[1] = src1_data_i;

    // ----------------------------------------------------------------------
    // operand wakeup
    // ----------------------------------------------------------------------

    // on alloc the buses are snooped against the incoming tags
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (alloc_i) begin
                base_rdy[k]  = src_rdy[k];
                base_tag[k]  = src_tag[k];
                base_data[k] = src_data[k];
            end else begin
                base_rdy[k]  = rdy_q[k];
                base_tag[k]  = tag_q[k];
                base_data[k] = data_q[k];
            end
            nxt_rdy[k]  = base_rdy[k];
            nxt_data[k] = base_data[k];
            if (!base_rdy[k]) begin
                if (fwd_valid_i && (fwd_tag_i == base_tag[k])) begin
                    nxt_rdy[k]  = 1'b1;
                    nxt_data[k] = fwd_data_i;
                end else if (cdb_valid_i && (cdb_tag_i == base_tag[k])) begin
                    nxt_rdy[k]  = 1'b1;
                    nxt_data[k] = cdb_data_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            op_q      <= op_i;
            dst_tag_q <= dst_tag_i;
        end
        if (alloc_i || (state_q == WAITING)) begin
            for (int k = 0; k < 2; k++) begin
                rdy_q[k]  <= nxt_rdy[k];
                tag_q[k]  <= base_tag[k];
                data_q[k] <= nxt_data[k];
            end
        end
    end

    // ----------------------------------------------------------------------
    // entry state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            state_q <= EMPTY;
        end else if (issue_i) begin
            state_q <= EMPTY;
        end else if (alloc_i) begin
            state_q <= (nxt_rdy[0] && nxt_rdy[1]) ? READY : WAITING;
        end else if ((state_q == WAITING) && nxt_rdy[0] && nxt_rdy[1]) begin
            state_q <= READY;
        end
    end

    assign occupied_o = (state_q != EMPTY);
    assign ready_o    = (state_q == READY);
    assign op_o       = op_q;
    assign dst_tag_o  = dst_tag_q;
    assign opnd0_o    = data_q[0];
    assign opnd1_o    = data_q[1];

    // controller must only allocate a free slot, never one being issued
    a_alloc_free: assert property (
        @(posedge clk) disable iff (!rst_n_i) alloc_i |-> (state_q == EMPTY));

    a_alloc_issue: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(alloc_i && issue_i));

endmodule

`default_nettype wire

/* iq_ctrl.sv */
`default_nettype none

`include "alu_iq_macros.svh"

module iq_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic                 dispatch_valid_i,

    input  logic [`IQ_DEPTH-1:0] entry_occupied_i,
    input  logic [`IQ_DEPTH-1:0] entry_ready_i,

    output logic [`IQ_DEPTH-1:0] alloc_o,
    output logic [`IQ_DEPTH-1:0] issue_o,
    output logic                 issue_valid_o,
    output logic                 entry_ready_o
);

    localparam int IDX_BITS = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;

    logic [`AGE_BITS-1:0] age_q [`IQ_DEPTH];

    logic                 sel_found;
    logic [IDX_BITS-1:0]  sel_idx;
    logic [`AGE_BITS-1:0] best_age;

    // ----------------------------------------------------------------------
    // allocation
    // ----------------------------------------------------------------------

    // lowest-index free entry takes the dispatch
    always_comb begin
        logic free_found;
        free_found = 1'b0;
        alloc_o    = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!entry_occupied_i[i] && !free_found) begin
                alloc_o[i] = dispatch_valid_i && !flush_i;
                free_found = 1'b1;
            end
        end
    end

    // queue not full from registered entry state
    assign entry_ready_o = |(~entry_occupied_i);

    // ----------------------------------------------------------------------
    // age counters
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (alloc_o[i]) begin
                    age_q[i] <= '0;
                end else if (entry_occupied_i[i] && (age_q[i] != '1)) begin
                    // saturates at all ones
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // oldest-ready select
    // ----------------------------------------------------------------------

    // strict compare keeps ties on the lower index
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        best_age  = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (entry_ready_i[i] && (!sel_found || (age_q[i] > best_age))) begin
                sel_found = 1'b1;
                sel_idx   = IDX_BITS'(i);
                best_age  = age_q[i];
            end
        end
    end

    always_comb begin
        issue_o          = '0;
        issue_o[sel_idx] = sel_found;
    end

    assign issue_valid_o = sel_found;

    // issue goes to one occupied entry at most
    a_issue_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(issue_o) && ((issue_o & ~entry_occupied_i) == '0));

    // dispatch source has to honour the queue-not-full flag
    a_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i) dispatch_valid_i |-> entry_ready_o);

endmodule

`default_nettype wire

/* alu_exec.sv */
`default_nettype none

`include "alu_iq_macros.svh"

module alu_exec
    import alu_iq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic [`IQ_DEPTH-1:0] issue_i,
    input  logic                 issue_valid_i,

    // fields from every entry
    input  alu_op_e              op_i      [`IQ_DEPTH],
    input  tag_t                 dst_tag_i [`IQ_DEPTH],
    input  word_t                opnd0_i   [`IQ_DEPTH],
    input  word_t                opnd1_i   [`IQ_DEPTH],

    output logic                 result_valid_o,
    output tag_t                 result_tag_o,
    output word_t                result_data_o
);

    alu_op_e sel_op;
    tag_t    sel_tag;
    word_t   sel_a;
    word_t   sel_b;
    word_t   alu_res;

    logic    valid_q;
    tag_t    tag_q;
    word_t   data_q;

    // ----------------------------------------------------------------------
    // operand mux, issue_i is one-hot
    // ----------------------------------------------------------------------

    always_comb begin
        sel_op  = ADD;
        sel_tag = '0;
        sel_a   = '0;
        sel_b   = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (issue_i[i]) begin
                sel_op  = op_i[i];
                sel_tag = dst_tag_i[i];
                sel_a   = opnd0_i[i];
                sel_b   = opnd1_i[i];
            end
        end
    end

    // ----------------------------------------------------------------------
    // alu
    // ----------------------------------------------------------------------

    always_comb begin
        case (sel_op)
            ADD:     alu_res = sel_a + sel_b;
            SUB:     alu_res = sel_a - sel_b;
            AND:     alu_res = sel_a & sel_b;
            OR:      alu_res = sel_a | sel_b;
            XOR:     alu_res = sel_a ^ sel_b;
            SLL:     alu_res = sel_a << sel_b[4:0];
            SRL:     alu_res = sel_a >> sel_b[4:0];
            SLT:     alu_res = word_t'($signed(sel_a) < $signed(sel_b));
            default: alu_res = '0;
        endcase
    end

    // result register, flush kills the one in flight
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            tag_q  <= sel_tag;
            data_q <= alu_res;
        end
    end

    assign result_valid_o = valid_q;
    assign result_tag_o   = tag_q;
    assign result_data_o  = data_q;

endmodule

`default_nettype wire

/* alu_issue_unit.sv */
`default_nettype none

`include "alu_iq_macros.svh"

module alu_issue_unit
    import alu_iq_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,

    // dispatch
    input  logic    dispatch_valid_i,
    input  alu_op_e dispatch_op_i,
    input  tag_t    dispatch_dst_tag_i,
    input  word_t   src0_data_i,
    input  tag_t    src0_tag_i,
    input  logic    src0_rdy_i,
    input  word_t   src1_data_i,
    input  tag_t    src1_tag_i,
    input  logic    src1_rdy_i,

    // external common data bus
    input  logic    cdb_valid_i,
    input  tag_t    cdb_tag_i,
    input  word_t   cdb_data_i,

    output logic    entry_ready_o,

    output logic    result_valid_o,
    output tag_t    result_tag_o,
    output word_t   result_data_o
);

    logic [`IQ_DEPTH-1:0] alloc;
    logic [`IQ_DEPTH-1:0] issue;
    logic                 issue_valid;
    logic [`IQ_DEPTH-1:0] entry_occupied;
    logic [`IQ_DEPTH-1:0] entry_ready;

    alu_op_e entry_op      [`IQ_DEPTH];
    tag_t    entry_dst_tag [`IQ_DEPTH];
    word_t   entry_opnd0   [`IQ_DEPTH];
    word_t   entry_opnd1   [`IQ_DEPTH];

    // ----------------------------------------------------------------------
    // controller
    // ----------------------------------------------------------------------

    iq_ctrl u_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .entry_occupied_i (entry_occupied),
        .entry_ready_i    (entry_ready),
        .alloc_o          (alloc),
        .issue_o          (issue),
        .issue_valid_o    (issue_valid),
        .entry_ready_o    (entry_ready_o)
    );

    // ----------------------------------------------------------------------
    // queue entries
    // ----------------------------------------------------------------------

    // result bus loops back as the forwarding bus
    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : gen_entry
        iq_entry u_entry (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .alloc_i     (alloc[i]),
            .issue_i     (issue[i]),
            .op_i        (dispatch_op_i),
            .dst_tag_i   (dispatch_dst_tag_i),
            .src0_data_i (src0_data_i),
            .src0_tag_i  (src0_tag_i),
            .src0_rdy_i  (src0_rdy_i),
            .src1_data_i (src1_data_i),
            .src1_tag_i  (src1_tag_i),
            .src1_rdy_i  (src1_rdy_i),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .fwd_valid_i (result_valid_o),
            .fwd_tag_i   (result_tag_o),
            .fwd_data_i  (result_data_o),
            .occupied_o  (entry_occupied[i]),
            .ready_o     (entry_ready[i]),
            .op_o        (entry_op[i]),
            .dst_tag_o   (entry_dst_tag[i]),
            .opnd0_o     (entry_opnd0[i]),
            .opnd1_o     (entry_opnd1[i])
        );
    end

    // ----------------------------------------------------------------------
    // execution stage
    // ----------------------------------------------------------------------

    alu_exec u_exec (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .issue_i        (issue),
        .issue_valid_i  (issue_valid),
        .op_i           (entry_op),
        .dst_tag_i      (entry_dst_tag),
        .opnd0_i        (entry_opnd0),
        .opnd1_i        (entry_opnd1),
        .result_valid_o (result_valid_o),
        .result_tag_o   (result_tag_o),
        .result_data_o  (result_data_o)
    );

endmodule

`default_nettype wire

/* tb_alu_issue_unit.sv */
`default_nettype none

module tb_alu_issue_unit
    import alu_iq_pkg::*;
();

    localparam int N_RAND  = 60;
    // directed instructions plus the random stream
    localparam int N_OPS   = 30 + N_RAND;
    localparam int WD_TIME = (N_OPS * 20 + 200) * 100;

    logic    clk;
    logic    rst_n_i;
    logic    flush_i;
    logic    dispatch_valid_i;
    alu_op_e dispatch_op_i;
    tag_t    dispatch_dst_tag_i;
    word_t   src0_data_i;
    tag_t    src0_tag_i;
    logic    src0_rdy_i;
    word_t   src1_data_i;
    tag_t    src1_tag_i;
    logic    src1_rdy_i;
    logic    cdb_valid_i;
    tag_t    cdb_tag_i;
    word_t   cdb_data_i;
    logic    entry_ready_o;
    logic    result_valid_o;
    tag_t    result_tag_o;
    word_t   result_data_o;

    // reference model indexed by tag
    // alu tags 0..7 and external tags 8..15
    logic    pend     [16];
    logic    known    [16];
    word_t   kval     [16];
    alu_op_e r_op     [16];
    logic    r_have   [16][2];
    tag_t    r_src    [16][2];
    word_t   r_val    [16][2];
    int      disp_cyc [16];
    int      done_cyc [16];
    int      ext_cyc  [16];
    tag_t    done_q   [$];

    int unsigned lcg_state  = 32'd39;
    int          cycle      = 0;
    int          mismatches = 0;
    int          failures   = 0;

    alu_issue_unit dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------------------------------------
    // random numbers and the opcode rules
    // ----------------------------------------------------------------------

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic word_t rand_word();
        word_t hi;
        hi = word_t'(next_rand());
        return (hi << 16) | word_t'(next_rand());
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic logic any_pending();
        logic p;
        p = 1'b0;
        for (int i = 0; i < 16; i++) begin
            p = p | pend[i];
        end
        return p;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at time %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    task automatic clear_model();
        for (int i = 0; i < 16; i++) begin
            pend[i]     = 1'b0;
            known[i]    = 1'b0;
            done_cyc[i] = -1;
        end
        done_q.delete();
    endtask

    // a broadcast hands its value to every waiting operand
    task automatic wake(input tag_t t, input word_t v);
        for (int i = 0; i < 16; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (pend[i] && !r_have[i][k] && (r_src[i][k] == t)) begin
                    r_have[i][k] = 1'b1;
                    r_val[i][k]  = v;
                end
            end
        end
    endtask

    task automatic check_result(input tag_t t, input word_t d);
        word_t exp;
        if (!pend[t]) begin
            report_failure($sformatf("result for tag %0d that is not in flight", t));
        end else begin
            if (!r_have[t][0] || !r_have[t][1]) begin
                report_failure($sformatf("tag %0d issued before its operands arrived", t));
            end
            exp = alu_model(r_op[t], r_val[t][0], r_val[t][1]);
            if (d !== exp) begin
                report_mismatch($sformatf("tag %0d result %h, expected %h", t, d, exp));
            end
            pend[t]     = 1'b0;
            known[t]    = 1'b1;
            kval[t]     = exp;
            done_cyc[t] = cycle;
            done_q.push_back(t);
            wake(t, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n_i && result_valid_o) begin
            check_result(result_tag_o, result_data_o);
        end
    end

    // ----------------------------------------------------------------------
    // drivers
    // ----------------------------------------------------------------------

    task automatic step();
        @(posedge clk);
        #1;
        dispatch_valid_i = 1'b0;
        cdb_valid_i      = 1'b0;
        flush_i          = 1'b0;
    endtask

    // w0/w1 set means the source waits on its tag
    task automatic dispatch(input alu_op_e op, input tag_t dst,
                            input logic w0, input tag_t s0, input word_t v0,
                            input logic w1, input tag_t s1, input word_t v1);
        logic  wt [2];
        tag_t  st [2];
        word_t sv [2];
        wt[0] = w0;
        wt[1] = w1;
        st[0] = s0;
        st[1] = s1;
        sv[0] = v0;
        sv[1] = v1;
        if (!entry_ready_o) begin
            report_failure($sformatf("queue full, tag %0d could not be dispatched", dst));
            return;
        end
        // already broadcast tags go in as ready data
        for (int k = 0; k < 2; k++) begin
            if (wt[k] && known[st[k]]) begin
                wt[k] = 1'b0;
                sv[k] = kval[st[k]];
            end
            r_have[dst][k] = !wt[k];
            r_src[dst][k]  = st[k];
            r_val[dst][k]  = sv[k];
        end
        pend[dst]          = 1'b1;
        known[dst]         = 1'b0;
        r_op[dst]          = op;
        disp_cyc[dst]      = cycle;
        dispatch_valid_i   = 1'b1;
        dispatch_op_i      = op;
        dispatch_dst_tag_i = dst;
        src0_rdy_i         = !wt[0];
        src0_tag_i         = st[0];
        src0_data_i        = sv[0];
        src1_rdy_i         = !wt[1];
        src1_tag_i         = st[1];
        src1_data_i        = sv[1];
    endtask

    task automatic cdb_send(input tag_t t, input word_t v);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = t;
        cdb_data_i  = v;
        known[t]    = 1'b1;
        kval[t]     = v;
        wake(t, v);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (any_pending() && (n < max_cycles)) begin
            step();
            n++;
        end
        if (any_pending()) begin
            report_failure($sformatf("results still outstanding after %0d cycles", max_cycles));
            for (int i = 0; i < 16; i++) begin
                pend[i] = 1'b0;
            end
        end
    endtask

    task automatic pick_source(output logic w, output tag_t t);
        int unsigned r;
        r = next_rand() % 3;
        if (r == 0) begin
            w = 1'b0;
            t = '0;
        end else if (r == 1) begin
            t = tag_t'(next_rand() % 8);
            w = pend[t] || known[t];
        end else begin
            t = tag_t'(8 + next_rand() % 8);
            w = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequences
    // ----------------------------------------------------------------------

    task automatic opcode_sweep();
        tag_t t;
        for (int o = 0; o < 8; o++) begin
            t = tag_t'(o);
            clear_model();
            dispatch(alu_op_e'(3'(o)), t, 1'b0, 4'd0, rand_word(), 1'b0, 4'd0, rand_word());
            wait_drain(10);
            if (done_cyc[t] != disp_cyc[t] + 2) begin
                report_mismatch($sformatf("op %0d done in cycle %0d, expected %0d",
                                          o, done_cyc[t], disp_cyc[t] + 2));
            end
            if (result_valid_o) begin
                report_mismatch("result_valid_o high for more than one cycle");
            end
        end
    endtask

    task automatic ext_wakeup();
        int c;
        clear_model();
        dispatch(SUB, 4'd0, 1'b1, 4'd8, '0, 1'b0, 4'd0, rand_word());
        repeat (1 + next_rand() % 5) step();
        c = cycle;
        cdb_send(4'd8, rand_word());
        wait_drain(10);
        if (done_cyc[0] != c + 2) begin
            report_mismatch($sformatf("late wakeup done in cycle %0d, expected %0d",
                                      done_cyc[0], c + 2));
        end
        // strobe in the dispatch cycle itself
        dispatch(SLT, 4'd1, 1'b0, 4'd0, rand_word(), 1'b1, 4'd9, '0);
        cdb_send(4'd9, rand_word());
        wait_drain(10);
        if (done_cyc[1] != disp_cyc[1] + 2) begin
            report_mismatch($sformatf("same-cycle wakeup done in cycle %0d, expected %0d",
                                      done_cyc[1], disp_cyc[1] + 2));
        end
    endtask

    task automatic dependency_chain();
        clear_model();
        dispatch(ADD, 4'd0, 1'b0, 4'd0, rand_word(), 1'b0, 4'd0, rand_word());
        for (int k = 1; k < 4; k++) begin
            step();
            dispatch(alu_op_e'(3'(next_rand() % 8)), tag_t'(k), 1'b1, tag_t'(k - 1), '0,
                     1'b0, 4'd0, rand_word());
        end
        wait_drain(20);
        for (int k = 1; k < 4; k++) begin
            if (done_cyc[k] != done_cyc[k - 1] + 2) begin
                report_mismatch($sformatf("chain tag %0d done in cycle %0d, expected %0d",
                                          k, done_cyc[k], done_cyc[k - 1] + 2));
            end
        end
    endtask

    task automatic inorder_stream();
        clear_model();
        for (int k = 0; k < 8; k++) begin
            dispatch(alu_op_e'(3'(next_rand() % 8)), tag_t'(k), 1'b0, 4'd0, rand_word(),
                     1'b0, 4'd0, rand_word());
            step();
        end
        wait_drain(20);
        if (done_q.size() != 8) begin
            report_mismatch($sformatf("%0d stream results, expected 8", done_q.size()));
        end else begin
            for (int k = 0; k < 8; k++) begin
                if (done_q[k] != tag_t'(k)) begin
                    report_mismatch($sformatf("stream slot %0d has tag %0d", k, done_q[k]));
                end
            end
        end
    endtask

    task automatic queue_full();
        int n;
        clear_model();
        dispatch(OR, 4'd0, 1'b1, 4'd8, '0, 1'b0, 4'd0, rand_word());
        step();
        dispatch(XOR, 4'd1, 1'b1, 4'd0, '0, 1'b0, 4'd0, rand_word());
        step();
        dispatch(ADD, 4'd2, 1'b1, 4'd9, '0, 1'b0, 4'd0, rand_word());
        step();
        dispatch(AND, 4'd3, 1'b0, 4'd0, rand_word(), 1'b1, 4'd10, '0);
        step();
        if (entry_ready_o) begin
            report_mismatch("entry_ready_o high with four waiting entries");
        end
        cdb_send(4'd8, rand_word());
        step();
        n = 0;
        while (!entry_ready_o && (n < 5)) begin
            step();
            n++;
        end
        if (!entry_ready_o) begin
            report_failure("entry_ready_o stayed low after an entry was woken");
        end
        // tag 4 takes the lowest entry but is the youngest
        dispatch(SUB, 4'd4, 1'b1, 4'd9, '0, 1'b0, 4'd0, rand_word());
        step();
        cdb_send(4'd9, rand_word());
        step();
        cdb_send(4'd10, rand_word());
        wait_drain(20);
        if (done_q.size() != 5) begin
            report_mismatch($sformatf("%0d full queue results, expected 5", done_q.size()));
        end else begin
            for (int k = 0; k < 5; k++) begin
                if (done_q[k] != tag_t'(k)) begin
                    report_mismatch($sformatf("full queue slot %0d has tag %0d",
                                              k, done_q[k]));
                end
            end
        end
    endtask

    task automatic flush_recovery();
        clear_model();
        dispatch(ADD, 4'd0, 1'b0, 4'd0, rand_word(), 1'b0, 4'd0, rand_word());
        step();
        // tag 0 issues at this edge and tag 1 is dropped
        dispatch(AND, 4'd1, 1'b1, 4'd8, '0, 1'b0, 4'd0, rand_word());
        flush_i = 1'b1;
        for (int i = 0; i < 16; i++) begin
            pend[i] = 1'b0;
        end
        step();
        for (int k = 0; k < 6; k++) begin
            if (result_valid_o) begin
                report_mismatch("result_valid_o high after flush");
            end
            if (!entry_ready_o) begin
                report_mismatch("entry_ready_o low after flush");
            end
            if (k == 2) begin
                cdb_send(4'd8, rand_word());
            end
            step();
        end
        dispatch(OR, 4'd2, 1'b0, 4'd0, rand_word(), 1'b0, 4'd0, rand_word());
        wait_drain(10);
    endtask

    task automatic random_stream();
        int   n_disp;
        int   base;
        logic found;
        tag_t dst;
        logic w0;
        logic w1;
        tag_t s0;
        tag_t s1;
        clear_model();
        for (int t = 8; t < 16; t++) begin
            ext_cyc[t] = cycle + 2 + int'(next_rand() % 150);
        end
        n_disp = 0;
        while (n_disp < N_RAND) begin
            // at most one external value per cycle
            for (int t = 8; t < 16; t++) begin
                if (!cdb_valid_i && !known[t] && (cycle >= ext_cyc[t])) begin
                    cdb_send(tag_t'(t), rand_word());
                end
            end
            if (entry_ready_o && ((next_rand() % 4) != 0)) begin
                base  = int'(next_rand() % 8);
                found = 1'b0;
                dst   = '0;
                for (int j = 0; j < 8; j++) begin
                    if (!found && !pend[(base + j) % 8]) begin
                        dst   = tag_t'((base + j) % 8);
                        found = 1'b1;
                    end
                end
                if (found) begin
                    pick_source(w0, s0);
                    pick_source(w1, s1);
                    dispatch(alu_op_e'(3'(next_rand() % 8)), dst, w0, s0, rand_word(),
                             w1, s1, rand_word());
                    n_disp++;
                end
            end
            step();
        end
        for (int t = 8; t < 16; t++) begin
            if (!known[t]) begin
                cdb_send(tag_t'(t), rand_word());
                step();
            end
        end
        wait_drain(100);
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------

    initial begin
        clk                = 1'b0;
        rst_n_i            = 1'b0;
        flush_i            = 1'b0;
        dispatch_valid_i   = 1'b0;
        dispatch_op_i      = ADD;
        dispatch_dst_tag_i = '0;
        src0_data_i        = '0;
        src0_tag_i         = '0;
        src0_rdy_i         = 1'b0;
        src1_data_i        = '0;
        src1_tag_i         = '0;
        src1_rdy_i         = 1'b0;
        cdb_valid_i        = 1'b0;
        cdb_tag_i          = '0;
        cdb_data_i         = '0;
        clear_model();
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        if (!entry_ready_o || result_valid_o) begin
            report_mismatch("entry_ready_o or result_valid_o wrong after reset");
        end
        opcode_sweep();
        ext_wakeup();
        dependency_chain();
        inorder_stream();
        queue_full();
        flush_recovery();
        random_stream();
        $display("done, %0d mismatches, %0d other errors", mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WD_TIME);
        $display("watchdog expired at time %0t, the run did not finish", $time);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* alu_issue_unit.f */
+incdir+.
alu_iq_pkg.sv
iq_entry.sv
iq_ctrl.sv
alu_exec.sv
alu_issue_unit.sv
tb_alu_issue_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the alu issue unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f alu_issue_unit.f --top-module tb_alu_issue_unit \
    --Mdir obj_dir -o sim_alu_issue_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_alu_issue_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
exit 1
